//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = bridge_tb
FILELIST = sources.f
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(TOOL), run $(TOP), check $(LOG) for the pass line"
	@echo "  clean  remove build output and log"
	@echo "  help   this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	-./obj_dir/$(TOP) | tee $(LOG)
	grep -q "^sim passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- dv/bridge_tb.sv
// bridge testbench with apb slave models, axi stimulus, response scoreboard and assertions
`include "bridge_macros.svh"

module bridge_tb
  import bridge_pkg::*;
();

  localparam int N_TXN    = 40;  // upper bound on requests issued
  localparam int WD_LIMIT = (N_TXN * (`BRIDGE_TIMEOUT + 20) + 200) * 20;

  logic s_axi_clk, arst_n;
  logic [31:0] s_axi_awaddr, s_axi_wdata, s_axi_araddr, s_axi_rdata, m_apb_paddr, m_apb_pwdata;
  logic [3:0] s_axi_wstrb, m_apb_psel, m_apb_pready, m_apb_pstrb;
  logic s_axi_awvalid, s_axi_awready, s_axi_wvalid, s_axi_wready, s_axi_bvalid, s_axi_bready;
  logic s_axi_arvalid, s_axi_arready, s_axi_rvalid, s_axi_rready;
  logic m_apb_penable, m_apb_pwrite, m_apb_pslverr;
  logic [3:0][31:0] m_apb_prdata;
  axi_resp_e s_axi_bresp, s_axi_rresp;

  integer seed = 32'h63f8f1f5;
  logic err_on = 0;   // slave 1 answers pslverr
  logic hang_on = 0;  // slave 3 never raises pready
  logic [31:0] slv_mem [4][256];
  logic [31:0] ref_mem [4][256];
  int wait_cnt [4];
  bit exp_w [$];
  logic [31:0] exp_addr [$];
  axi_resp_e exp_resp [$];
  logic [31:0] exp_data [$];  // read data, or write data seen on pwdata
  logic [3:0] exp_strb [$];   // zero for reads
  int accepted = 0;
  int pen_run = 0;            // access cycles in a row

  axi_apb_bridge DUT (.*);

  initial begin
    s_axi_clk = 0;
    forever #10 s_axi_clk = ~s_axi_clk;
  end

  task automatic value_mismatch(string name, logic [31:0] exp, logic [31:0] act);
    $display("[FAIL] t=%0t %s expected %h actual %h", $time, name, exp, act);
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic halt_with_error(string msg);
    $display("error at %0t %s", $time, msg);
    $display("sim failed");
    $fatal(1);
  endtask

  function automatic logic [31:0] fill_word(logic [31:0] a);
    return a ^ {a[15:0], a[31:16]} ^ 32'hc3a5_5a3c; // every address bit matters
  endfunction

  function automatic logic [31:0] merge(logic [31:0] old, logic [31:0] nw, logic [3:0] strb);
    logic [31:0] r;
    r = old;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) r[8*b +: 8] = nw[8*b +: 8]; // byte lanes by strobe
    end
    return r;
  endfunction

  // apb slaves, all driven on the falling edge
  always @(negedge s_axi_clk) begin
    m_apb_pready  = '0;
    m_apb_pslverr = err_on && m_apb_psel[1] && m_apb_penable;
    for (int i = 0; i < 4; i++) begin
      if (m_apb_psel[i] && !m_apb_penable) begin
        wait_cnt[i] = $random(seed) & 3; // setup picks 0..3 waits
      end else if (m_apb_psel[i] && !(hang_on && i == 3)) begin
        if (wait_cnt[i] == 0) begin
          m_apb_pready[i] = 1'b1;
          m_apb_prdata[i] = slv_mem[i][m_apb_paddr[9:2]];
          if (m_apb_pwrite && !(err_on && i == 1)) begin
            slv_mem[i][m_apb_paddr[9:2]] = merge(slv_mem[i][m_apb_paddr[9:2]],
                                                 m_apb_pwdata, m_apb_pstrb);
          end
        end else begin
          wait_cnt[i]--;
        end
      end
    end
  end

  // reference model at acceptance, apb and response checks on the oldest request
  always @(posedge s_axi_clk) begin
    logic [31:0] a;
    logic [1:0]  ix;
    bit          wr;
    bit          miss;  // outside the window or silent slave
    if (arst_n && |m_apb_psel) begin
      assert (exp_w.size() != 0)
        else halt_with_error("psel raised with no request outstanding");
      a = exp_addr[0];
      assert (a[31:12] == `BRIDGE_BASE_PAGE)
        else halt_with_error("psel raised for an address outside the window");
      assert (m_apb_psel == 4'(4'b1 << a[11:10]))
        else value_mismatch("m_apb_psel", 4'(4'b1 << a[11:10]), m_apb_psel);
      assert (m_apb_paddr == a) else value_mismatch("m_apb_paddr", a, m_apb_paddr);
      assert (m_apb_pwrite == exp_w[0])
        else value_mismatch("m_apb_pwrite", exp_w[0], m_apb_pwrite);
      assert (m_apb_pstrb == exp_strb[0])
        else value_mismatch("m_apb_pstrb", exp_strb[0], m_apb_pstrb);
      if (exp_w[0]) begin
        assert (m_apb_pwdata == exp_data[0])
          else value_mismatch("m_apb_pwdata", exp_data[0], m_apb_pwdata);
      end
    end
    if (!arst_n || !m_apb_penable) begin
      pen_run = 0;
    end else begin
      pen_run++;
    end
    assert (pen_run <= `BRIDGE_TIMEOUT) else halt_with_error("penable held past the timeout");
    if (arst_n && (s_axi_arready || s_axi_awready || s_axi_wready)) begin
      wr = !s_axi_arvalid;  // a read on offer wins
      assert (s_axi_arready == !wr) else value_mismatch("s_axi_arready", !wr, s_axi_arready);
      assert (s_axi_awready == wr) else value_mismatch("s_axi_awready", wr, s_axi_awready);
      assert (s_axi_wready == wr) else value_mismatch("s_axi_wready", wr, s_axi_wready);
      a    = wr ? s_axi_awaddr : s_axi_araddr;
      ix   = a[11:10];
      miss = a[31:12] != `BRIDGE_BASE_PAGE || (hang_on && ix == 3);
      accepted++;
      exp_w.push_back(wr);
      exp_addr.push_back(a);
      exp_strb.push_back(wr ? s_axi_wstrb : 4'h0);
      if (wr) begin
        exp_data.push_back(s_axi_wdata);
      end else if (miss) begin
        exp_data.push_back('0);
      end else begin
        exp_data.push_back(ref_mem[ix][a[9:2]]);
      end
      if (miss || (err_on && ix == 1)) begin
        exp_resp.push_back(SLVERR); // nothing written
      end else begin
        exp_resp.push_back(OKAY);
        if (wr) begin
          ref_mem[ix][a[9:2]] = merge(ref_mem[ix][a[9:2]], s_axi_wdata, s_axi_wstrb);
        end
      end
    end
    if (arst_n && ((s_axi_bvalid && s_axi_bready) || (s_axi_rvalid && s_axi_rready))) begin
      assert (exp_w.size() != 0)
        else halt_with_error("response with no request outstanding");
      assert (exp_w[0] == s_axi_bvalid)
        else value_mismatch("s_axi_bvalid", exp_w[0], s_axi_bvalid);
      if (s_axi_bvalid) begin
        assert (s_axi_bresp == exp_resp[0])
          else value_mismatch("s_axi_bresp", exp_resp[0], s_axi_bresp);
      end else begin
        assert (s_axi_rresp == exp_resp[0])
          else value_mismatch("s_axi_rresp", exp_resp[0], s_axi_rresp);
        assert (s_axi_rdata == exp_data[0])
          else value_mismatch("s_axi_rdata", exp_data[0], s_axi_rdata);
      end
      void'(exp_w.pop_front());
      void'(exp_addr.pop_front());
      void'(exp_resp.pop_front());
      void'(exp_data.pop_front());
      void'(exp_strb.pop_front());
    end
  end

  wire [9:0] quiet = {s_axi_bvalid, s_axi_rvalid, m_apb_psel, m_apb_penable,
                      s_axi_arready, s_axi_awready, s_axi_wready};
  a_rst_quiet: assert property (@(posedge s_axi_clk) !arst_n || $rose(arst_n) |-> quiet == '0)
    else value_mismatch("reset outputs", 0, quiet);

  // one request, held until the bridge takes it
  task automatic send(bit wr, logic [31:0] addr, logic [31:0] data, logic [3:0] strb);
    @(negedge s_axi_clk);
    {s_axi_awvalid, s_axi_wvalid, s_axi_arvalid} = {wr, wr, !wr};
    {s_axi_awaddr, s_axi_araddr, s_axi_wdata, s_axi_wstrb} = {addr, addr, data, strb};
    @(posedge s_axi_clk);
    while (!(s_axi_arready || s_axi_awready)) @(posedge s_axi_clk);
    @(negedge s_axi_clk);
    {s_axi_awvalid, s_axi_wvalid, s_axi_arvalid} = '0;
  endtask

  task automatic drain();
    while (exp_w.size() != 0) @(posedge s_axi_clk);
    @(negedge s_axi_clk);
  endtask

  initial begin
    logic [31:0] a;
    int          bp_start;  // acceptances before back-pressure
    for (int i = 0; i < 4; i++)
      for (int w = 0; w < 256; w++) begin
        a = {`BRIDGE_BASE_PAGE, 2'(i), 8'(w), 2'b00};
        slv_mem[i][w] = fill_word(a);
        ref_mem[i][w] = fill_word(a);
      end
    {s_axi_awvalid, s_axi_wvalid, s_axi_arvalid, s_axi_bready, s_axi_rready} = 5'b00011;
    {s_axi_awaddr, s_axi_araddr, s_axi_wdata, s_axi_wstrb} = '0;
    m_apb_pready = '0;
    m_apb_pslverr = 0;
    m_apb_prdata = '0;
    arst_n = 0;
    repeat (3) @(posedge s_axi_clk);
    @(negedge s_axi_clk) arst_n = 1;
    for (int i = 0; i < 4; i++)    // write then read in every region
      repeat (3) begin
        a = {`BRIDGE_BASE_PAGE, 2'(i), 8'($random(seed)), 2'b00};
        send(1, a, $random(seed), 4'($random(seed)));
        send(0, a, 0, 0);
      end
    send(1, 32'h5000_0100, 32'hdead_beef, 4'hf); // outside the window
    send(0, 32'h5000_0100, 0, 0);
    drain();
    err_on = 1;
    send(1, 32'h4000_0410, 32'h1234_5678, 4'hf);
    send(0, 32'h4000_0410, 0, 0);
    drain();
    err_on = 0;
    hang_on = 1;
    send(0, 32'h4000_0c20, 0, 0);
    send(1, 32'h4000_0c20, 32'h0bad_cafe, 4'hf);
    drain();
    hang_on = 0;
    {s_axi_bready, s_axi_rready} = 2'b00; // back-pressure, keep offering
    bp_start = accepted;
    for (int k = 0; k < 30; k++) begin
      {s_axi_awvalid, s_axi_wvalid, s_axi_arvalid} = {k[0], k[0], !k[0]};
      s_axi_awaddr = {`BRIDGE_BASE_PAGE, 2'(k), 8'(k), 2'b00};
      s_axi_araddr = s_axi_awaddr;
      {s_axi_wdata, s_axi_wstrb} = {32'($random(seed)), 4'hf};
      @(negedge s_axi_clk);
    end
    {s_axi_awvalid, s_axi_wvalid, s_axi_arvalid} = '0;
    assert (accepted - bp_start == `BRIDGE_FIFO_DEPTH + 2)
      else value_mismatch("accepted under back-pressure", `BRIDGE_FIFO_DEPTH + 2,
                          accepted - bp_start);
    {s_axi_bready, s_axi_rready} = 2'b11;
    drain();
    $display("sim passed");
    $finish;
  end

  initial begin
    #(WD_LIMIT);
    $display("watchdog expired before the tests completed");
    $display("sim failed");
    $fatal(1);
  end

endmodule

//--- logic/apb_xfer_fsm.sv
// apb transfer sequencer: window decode, setup/access phases, timeout and axi response drive
`include "bridge_macros.svh"

module apb_xfer_fsm
  import bridge_pkg::*;
(
  input  logic                                          s_axi_clk,
  input  logic                                          arst_n,
  bridge_req_if.dst                                     req_in,
  // apb master
  output logic [`BRIDGE_ADDR_W-1:0]                     m_apb_paddr,
  output logic [`BRIDGE_NUM_SLAVES-1:0]                 m_apb_psel,
  output logic                                          m_apb_penable,
  output logic                                          m_apb_pwrite,
  output logic [`BRIDGE_DATA_W-1:0]                     m_apb_pwdata,
  output logic [`BRIDGE_STRB_W-1:0]                     m_apb_pstrb,
  input  logic [`BRIDGE_NUM_SLAVES-1:0]                 m_apb_pready,
  input  logic [`BRIDGE_NUM_SLAVES-1:0][`BRIDGE_DATA_W-1:0] m_apb_prdata,
  input  logic                                          m_apb_pslverr,
  // axi responses
  output axi_resp_e                                     s_axi_bresp,
  output logic                                          s_axi_bvalid,
  input  logic                                          s_axi_bready,
  output logic [`BRIDGE_DATA_W-1:0]                     s_axi_rdata,
  output axi_resp_e                                     s_axi_rresp,
  output logic                                          s_axi_rvalid,
  input  logic                                          s_axi_rready
);

  localparam int TMO_W = $clog2(`BRIDGE_TIMEOUT + 1);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SETUP,
    ST_ACCESS,
    ST_RESP
  } state_e;

  state_e                    state_q;
  logic [TMO_W-1:0]          tmo_cnt_q; // access cycles left
  bridge_req_t               req_q;     // request in flight
  axi_resp_e                 resp_q;
  logic [`BRIDGE_DATA_W-1:0] rdata_q;
  apb_addr_u                 in_addr;   // queue head, split
  apb_addr_u                 cur_addr;  // held request, split
  logic                      take;      // pop this cycle
  logic                      in_window;
  logic                      apb_busy;  // setup or access
  logic                      sel_ready; // pready of addressed slave
  logic                      tmo_hit;   // last allowed access cycle
  logic                      resp_done; // master took the response

  assign in_addr.raw  = req_in.req.addr;
  assign cur_addr.raw = req_q.addr;
  assign in_window    = in_addr.f.page == `BRIDGE_BASE_PAGE;
  assign req_in.ready = state_q == ST_IDLE; // pop only when idle
  assign take         = req_in.valid && req_in.ready;
  assign apb_busy     = (state_q == ST_SETUP) || (state_q == ST_ACCESS);
  assign sel_ready    = m_apb_pready[cur_addr.f.idx];
  assign tmo_hit      = tmo_cnt_q == TMO_W'(1);
  assign resp_done    = req_q.write ? s_axi_bready : s_axi_rready;

  always_ff @(posedge s_axi_clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q   <= ST_IDLE;
      tmo_cnt_q <= '0;
    end else begin
      case (state_q)
        ST_IDLE: if (take) state_q <= in_window ? ST_SETUP : ST_RESP; // miss answers at once
        ST_SETUP: begin
          state_q   <= ST_ACCESS;
          tmo_cnt_q <= TMO_W'(`BRIDGE_TIMEOUT);
        end
        ST_ACCESS: begin
          if (sel_ready || tmo_hit) state_q <= ST_RESP;
          else tmo_cnt_q <= tmo_cnt_q - 1'b1;
        end
        ST_RESP: if (resp_done) state_q <= ST_IDLE;
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // response defaults to slverr with zero data, covers miss and timeout
  always_ff @(posedge s_axi_clk) begin
    if (take) begin
      req_q   <= req_in.req;
      resp_q  <= SLVERR;
      rdata_q <= '0;
    end else if ((state_q == ST_ACCESS) && sel_ready) begin
      resp_q  <= m_apb_pslverr ? SLVERR : OKAY;
      rdata_q <= m_apb_prdata[cur_addr.f.idx]; // sampled at pready
    end
  end

  // one-hot select from the slave index
  always_comb begin
    for (int i = 0; i < `BRIDGE_NUM_SLAVES; i++) begin
      m_apb_psel[i] = apb_busy && (cur_addr.f.idx == `BRIDGE_SLV_IDX_W'(i));
    end
  end

  assign m_apb_paddr   = cur_addr.raw;
  assign m_apb_penable = state_q == ST_ACCESS;
  assign m_apb_pwrite  = req_q.write;
  assign m_apb_pwdata  = req_q.data;
  assign m_apb_pstrb   = req_q.strb;

  assign s_axi_bvalid = (state_q == ST_RESP) && req_q.write;
  assign s_axi_rvalid = (state_q == ST_RESP) && !req_q.write;
  assign s_axi_bresp  = resp_q;
  assign s_axi_rresp  = resp_q;
  assign s_axi_rdata  = rdata_q;

  a_psel_onehot: assert property (@(posedge s_axi_clk) disable iff (!arst_n)
    $onehot0(m_apb_psel));
  a_penable_sel: assert property (@(posedge s_axi_clk) disable iff (!arst_n)
    m_apb_penable |-> |m_apb_psel);
  a_resp_excl: assert property (@(posedge s_axi_clk) disable iff (!arst_n)
    !(s_axi_bvalid && s_axi_rvalid));

endmodule

//--- logic/axi_apb_bridge.sv
// axi-lite to apb bridge top: request capture, request queue and apb sequencer in one clock
`include "bridge_macros.svh"

module axi_apb_bridge
  import bridge_pkg::*;
(
  input  logic                                          s_axi_clk,
  input  logic                                          arst_n,
  // axi-lite slave
  input  logic [`BRIDGE_ADDR_W-1:0]                     s_axi_awaddr,
  input  logic                                          s_axi_awvalid,
  output logic                                          s_axi_awready,
  input  logic [`BRIDGE_DATA_W-1:0]                     s_axi_wdata,
  input  logic [`BRIDGE_STRB_W-1:0]                     s_axi_wstrb,
  input  logic                                          s_axi_wvalid,
  output logic                                          s_axi_wready,
  output axi_resp_e                                     s_axi_bresp,
  output logic                                          s_axi_bvalid,
  input  logic                                          s_axi_bready,
  input  logic [`BRIDGE_ADDR_W-1:0]                     s_axi_araddr,
  input  logic                                          s_axi_arvalid,
  output logic                                          s_axi_arready,
  output axi_resp_e                                     s_axi_rresp,
  output logic                                          s_axi_rvalid,
  output logic [`BRIDGE_DATA_W-1:0]                     s_axi_rdata,
  input  logic                                          s_axi_rready,
  // apb master, one psel/pready/prdata word per slave
  output logic [`BRIDGE_ADDR_W-1:0]                     m_apb_paddr,
  output logic [`BRIDGE_NUM_SLAVES-1:0]                 m_apb_psel,
  output logic                                          m_apb_penable,
  output logic                                          m_apb_pwrite,
  output logic [`BRIDGE_DATA_W-1:0]                     m_apb_pwdata,
  output logic [`BRIDGE_STRB_W-1:0]                     m_apb_pstrb,
  input  logic [`BRIDGE_NUM_SLAVES-1:0]                 m_apb_pready,
  input  logic [`BRIDGE_NUM_SLAVES-1:0][`BRIDGE_DATA_W-1:0] m_apb_prdata,
  input  logic                                          m_apb_pslverr
);

  bridge_req_if cap2q ();  // capture -> queue
  bridge_req_if q2apb ();  // queue -> sequencer

  // axi request side, same-named ports by .*
  axi_req_capture u_capture (
    .req_out (cap2q),
    .*
  );

  req_fifo u_queue (
    .s_axi_clk (s_axi_clk),
    .arst_n    (arst_n),
    .push      (cap2q),
    .pop       (q2apb)
  );

  // apb phases plus b/r responses
  apb_xfer_fsm u_xfer (
    .req_in (q2apb),
    .*
  );

endmodule

//--- logic/axi_req_capture.sv
// axi request capture with read-over-write arbitration into a one-entry request register
`include "bridge_macros.svh"

module axi_req_capture
  import bridge_pkg::*;
(
  input  logic                      s_axi_clk,
  input  logic                      arst_n,
  // write address and data taken together
  input  logic [`BRIDGE_ADDR_W-1:0] s_axi_awaddr,
  input  logic                      s_axi_awvalid,
  output logic                      s_axi_awready,
  input  logic [`BRIDGE_DATA_W-1:0] s_axi_wdata,
  input  logic [`BRIDGE_STRB_W-1:0] s_axi_wstrb,
  input  logic                      s_axi_wvalid,
  output logic                      s_axi_wready,
  // read address
  input  logic [`BRIDGE_ADDR_W-1:0] s_axi_araddr,
  input  logic                      s_axi_arvalid,
  output logic                      s_axi_arready,
  // toward the request queue
  bridge_req_if.src                 req_out
);

  logic        full_q;   // register holds a request
  bridge_req_t req_q;    // captured request
  logic        can_load; // empty or emptying this cycle
  logic        rd_take;  // read wins
  logic        wr_take;  // write with both aw and w present

  assign can_load = !full_q || req_out.ready;
  assign rd_take  = can_load && s_axi_arvalid; // read has priority
  assign wr_take  = can_load && !s_axi_arvalid && s_axi_awvalid && s_axi_wvalid;

  // readies pulse for one cycle and stay low under back-pressure
  assign s_axi_arready = rd_take;
  assign s_axi_awready = wr_take;
  assign s_axi_wready  = wr_take; // w goes with aw

  always_ff @(posedge s_axi_clk or negedge arst_n) begin
    if (!arst_n) begin
      full_q <= 1'b0;
    end else if (rd_take || wr_take) begin
      full_q <= 1'b1;  // new request replaces any drained one
    end else if (req_out.ready) begin
      full_q <= 1'b0;  // queue took it
    end
  end

  always_ff @(posedge s_axi_clk) begin
    if (rd_take) begin
      req_q.write <= 1'b0;
      req_q.addr  <= s_axi_araddr;
      req_q.data  <= '0;          // reads carry no payload
      req_q.strb  <= '0;
    end else if (wr_take) begin
      req_q.write <= 1'b1;
      req_q.addr  <= s_axi_awaddr;
      req_q.data  <= s_axi_wdata;
      req_q.strb  <= s_axi_wstrb; // straight through to pstrb later
    end
  end

  assign req_out.valid = full_q;
  assign req_out.req   = req_q;

  // never grant read and write together
  a_one_grant: assert property (@(posedge s_axi_clk) disable iff (!arst_n)
    !(s_axi_arready && s_axi_awready));

endmodule

//--- logic/bridge_macros.svh
// bridge macros: bus widths, apb slave map, queue depth and timeout of the axi-lite to apb bridge
`ifndef BRIDGE_MACROS_SVH
`define BRIDGE_MACROS_SVH

// bus widths
`define BRIDGE_ADDR_W 32
`define BRIDGE_DATA_W 32
`define BRIDGE_STRB_W 4              // one strobe per data byte

// apb slave map, addr = {page, slave index, offset}
`define BRIDGE_NUM_SLAVES 4
`define BRIDGE_SLV_IDX_W 2           // log2 of slave count
`define BRIDGE_OFFSET_W 10           // 1 KiB region per slave
`define BRIDGE_PAGE_W 20             // bits above the slave index
`define BRIDGE_BASE_PAGE 20'h40000   // window 4000_0000 .. 4000_0FFF

// request queue between capture and apb sequencer
`define BRIDGE_FIFO_DEPTH 4

// access cycles granted before a silent slave is cut off
`define BRIDGE_TIMEOUT 10

`endif

//--- logic/bridge_pkg.sv
// bridge package: axi response codes, the request word and the decoded apb address view
`include "bridge_macros.svh"

package bridge_pkg;

  // axi-lite response codes, only the two the bridge returns
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } axi_resp_e;

  // address split into window page, slave select and byte offset
  typedef struct packed {
    logic [`BRIDGE_PAGE_W-1:0]    page;   // must match base page
    logic [`BRIDGE_SLV_IDX_W-1:0] idx;    // which apb slave
    logic [`BRIDGE_OFFSET_W-1:0]  offset; // byte inside the region
  } apb_addr_fields_t;

  // one address word, seen raw or split
  typedef union packed {
    logic [`BRIDGE_ADDR_W-1:0] raw;
    apb_addr_fields_t          f;
  } apb_addr_u;

  // one accepted axi request, 69 bits
  typedef struct packed {
    logic                      write; // 1 = write, 0 = read
    logic [`BRIDGE_ADDR_W-1:0] addr;
    logic [`BRIDGE_DATA_W-1:0] data;  // zero for reads
    logic [`BRIDGE_STRB_W-1:0] strb;  // zero for reads
  } bridge_req_t;

endpackage

//--- logic/bridge_req_if.sv
// bridge request channel: valid/ready handshake carrying one bridge request between stages
interface bridge_req_if
  import bridge_pkg::*;
();

  // transfer when valid && ready in the same cycle
  // valid holds with req stable until that cycle
  logic        valid; // request on offer
  logic        ready; // sink takes it this cycle
  bridge_req_t req;   // the request itself

  // producer side
  modport src (
    output valid,
    output req,
    input  ready
  );

  // consumer side
  modport dst (
    input  valid,
    input  req,
    output ready
  );

endinterface

//--- logic/req_fifo.sv
// request queue: first-in first-out buffer of bridge requests between capture and apb sequencer
`include "bridge_macros.svh"

module req_fifo
  import bridge_pkg::*;
(
  input logic       s_axi_clk,
  input logic       arst_n,
  bridge_req_if.dst push, // from capture
  bridge_req_if.src pop   // to apb sequencer
);

  localparam int PTR_W = $clog2(`BRIDGE_FIFO_DEPTH);
  localparam int CNT_W = $clog2(`BRIDGE_FIFO_DEPTH + 1);

  bridge_req_t      mem [`BRIDGE_FIFO_DEPTH]; // circular store
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;   // entries held
  logic             do_push;
  logic             do_pop;

  assign push.ready = count != CNT_W'(`BRIDGE_FIFO_DEPTH); // not full
  assign pop.valid  = count != '0;                          // not empty
  assign pop.req    = mem[rd_ptr];                          // head
  assign do_push    = push.valid && push.ready;
  assign do_pop     = pop.valid && pop.ready;

  always_ff @(posedge s_axi_clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(`BRIDGE_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(`BRIDGE_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count; // both or neither
      endcase
    end
  end

  // entry storage
  always_ff @(posedge s_axi_clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push.req;
    end
  end

  a_count_max: assert property (@(posedge s_axi_clk) disable iff (!arst_n)
    count <= CNT_W'(`BRIDGE_FIFO_DEPTH));

  // head must not move while the sequencer is busy
  a_head_hold: assert property (@(posedge s_axi_clk) disable iff (!arst_n)
    pop.valid && !pop.ready |=> pop.valid && $stable(pop.req));

endmodule

//--- sources.f
+incdir+logic
logic/bridge_pkg.sv
logic/bridge_req_if.sv
logic/axi_req_capture.sv
logic/req_fifo.sv
logic/apb_xfer_fsm.sv
logic/axi_apb_bridge.sv
dv/bridge_tb.sv
